/* logic/guard_pkg.sv */
package guard_pkg;

  // Link widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned CntWidth  = 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [CntWidth-1:0]  cnt_t;

  // Snapshots of the observed AXI write channels
  typedef struct packed {
    logic  valid;
    logic  ready;
    id_t   id;
    addr_t addr;
  } aw_snap_t;

  typedef struct packed {
    logic valid;
    logic ready;
    logic last;
  } w_snap_t;

  typedef struct packed {
    logic valid;
    logic ready;
    id_t  id;
  } b_snap_t;

  // Configuration write strobe
  typedef struct packed {
    logic       we;
    logic [1:0] addr;
    cnt_t       data;
  } cfg_wr_t;

  // Live cycle budgets
  typedef struct packed {
    cnt_t aw_stall;
    cnt_t aw_wlast;
    cnt_t wlast_b;
  } budgets_t;

  typedef enum logic [2:0] {
    NONE,
    AW_STALL,
    WLAST_LATE,
    B_LATE,
    STRAY_W,
    OVERFLOW,
    UNWANTED_B
  } fault_cause_e;

  // Fault event from a checker, also used as the latched record
  typedef struct packed {
    logic         valid;
    fault_cause_e cause;
    id_t          id;
    addr_t        addr;
  } fault_t;

  // Register map, address 3 is unused
  localparam logic [1:0] RegAwStall = 2'd0;
  localparam logic [1:0] RegAwWlast = 2'd1;
  localparam logic [1:0] RegWlastB  = 2'd2;

  localparam cnt_t DefAwStall = 8'd8;
  localparam cnt_t DefAwWlast = 8'd16;
  localparam cnt_t DefWlastB  = 8'd16;

endpackage

/* logic/guard_regs.sv */
`timescale 1ns/1ns

module guard_regs import guard_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  cfg_wr_t  cfg_wr_i,
  input  logic     fault_clear_i,
  input  fault_t   stall_fault_i,
  input  fault_t   txn_fault_i,
  output budgets_t budgets_o,
  output logic     frozen_o,
  output logic     flush_o,
  output logic     irq_o,
  output logic     reset_req_o,
  output fault_t   fault_o
);

  budgets_t budgets_q;
  fault_t   fault_q;
  fault_t   fault_sel;
  logic     flush_q;

  // Budget registers, written by the config strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      budgets_q <= '{aw_stall: DefAwStall, aw_wlast: DefAwWlast, wlast_b: DefWlastB};
    end else if (cfg_wr_i.we) begin
      case (cfg_wr_i.addr)
        RegAwStall: budgets_q.aw_stall <= cfg_wr_i.data;
        RegAwWlast: budgets_q.aw_wlast <= cfg_wr_i.data;
        RegWlastB:  budgets_q.wlast_b  <= cfg_wr_i.data;
        default: begin
        end
      endcase
    end
  end

  assign budgets_o = budgets_q;

  // The tracker already ranks its own causes, all of which outrank AW_STALL
  always_comb begin
    if (txn_fault_i.valid) begin
      fault_sel = txn_fault_i;
    end else begin
      fault_sel = stall_fault_i;
    end
  end

  // Checkers stay frozen while a fault is held, at the clear and during the flush
  assign frozen_o = fault_q.valid | fault_clear_i | flush_q;

  // First fault is kept until software clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= '0;
    end else if (fault_clear_i) begin
      fault_q <= '0;
    end else if (!frozen_o && fault_sel.valid) begin
      fault_q <= fault_sel;
    end
  end

  // Flush follows the clear by one edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= fault_clear_i;
    end
  end

  assign flush_o = flush_q;

  // Interrupt and subordinate reset request both follow the record
  assign irq_o       = fault_q.valid;
  assign reset_req_o = fault_q.valid;
  assign fault_o     = fault_q;

endmodule

/* logic/aw_stall_monitor.sv */
`timescale 1ns/1ns

module aw_stall_monitor import guard_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  aw_snap_t aw_i,
  input  cnt_t     budget_i,
  input  logic     frozen_i,
  input  logic     flush_i,
  output fault_t   fault_o
);

  logic stalled;
  cnt_t run_q;

  assign stalled = aw_i.valid && !aw_i.ready;

  // Length of the current stall run, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= '0;
    end else if (flush_i) begin
      run_q <= '0;
    end else if (!frozen_i) begin
      if (!stalled) begin
        run_q <= '0;
      end else if (run_q != '1) begin
        run_q <= run_q + 1'b1;
      end
    end
  end

  // This edge samples stall cycle run_q+1
  always_comb begin
    fault_o = '0;
    if (!frozen_i && stalled && (run_q >= budget_i)) begin
      fault_o = '{valid: 1'b1, cause: AW_STALL, id: aw_i.id, addr: aw_i.addr};
    end
  end

endmodule

/* logic/id_queue.sv */
`timescale 1ns/1ns

module id_queue import guard_pkg::*; #(
  parameter int unsigned MaxTxns = 8,
  localparam int unsigned SlotW = $clog2(MaxTxns)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  id_t              push_id_i,
  input  id_t              lookup_id_i,
  input  logic             pop_i,
  output logic [SlotW-1:0] push_slot_o,
  output logic             full_o,
  output logic             head_valid_o,
  output logic [SlotW-1:0] head_slot_o
);

  localparam int unsigned NumIds = 2 ** IdWidth;

  typedef logic [SlotW-1:0] slot_t;

  // One ordered list per ID
  typedef struct packed {
    logic  valid;
    slot_t head;
    slot_t tail;
  } list_t;

  list_t              list_q [NumIds];
  list_t              list_d [NumIds];
  logic [MaxTxns-1:0] free_q;
  logic [MaxTxns-1:0] free_d;
  slot_t              next_q [MaxTxns];
  logic               link_we;
  slot_t              link_slot;

  // Lowest free slot
  always_comb begin
    push_slot_o = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        push_slot_o = slot_t'(i);
      end
    end
  end

  assign full_o       = ~|free_q;
  assign head_valid_o = list_q[lookup_id_i].valid;
  assign head_slot_o  = list_q[lookup_id_i].head;

  always_comb begin
    list_d    = list_q;
    free_d    = free_q;
    link_we   = 1'b0;
    link_slot = list_q[push_id_i].tail;

    // Pop first so that a push on the same ID sees the shortened list
    if (pop_i && head_valid_o) begin
      free_d[head_slot_o] = 1'b1;
      if (head_slot_o == list_q[lookup_id_i].tail) begin
        list_d[lookup_id_i].valid = 1'b0;
      end else begin
        list_d[lookup_id_i].head = next_q[head_slot_o];
      end
    end

    // Push slot is free before this edge, so it never equals the popped one
    if (push_i) begin
      free_d[push_slot_o] = 1'b0;
      if (list_d[push_id_i].valid) begin
        link_we                  = 1'b1;
        list_d[push_id_i].tail   = push_slot_o;
      end else begin
        list_d[push_id_i].valid = 1'b1;
        list_d[push_id_i].head  = push_slot_o;
        list_d[push_id_i].tail  = push_slot_o;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_q <= '1;
      for (int i = 0; i < NumIds; i++) begin
        list_q[i] <= '0;
      end
    end else if (flush_i) begin
      free_q <= '1;
      for (int i = 0; i < NumIds; i++) begin
        list_q[i] <= '0;
      end
    end else begin
      free_q <= free_d;
      list_q <= list_d;
    end
  end

  // Link from the old tail to the new entry
  always_ff @(posedge clk_i) begin
    if (link_we) begin
      next_q[link_slot] <= push_slot_o;
    end
  end

endmodule

/* logic/txn_tracker.sv */
`timescale 1ns/1ns

module txn_tracker import guard_pkg::*; #(
  parameter int unsigned MaxTxns = 8,
  localparam int unsigned SlotW = $clog2(MaxTxns)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  aw_snap_t         aw_i,
  input  w_snap_t          w_i,
  input  b_snap_t          b_i,
  input  budgets_t         budgets_i,
  input  logic             frozen_i,
  input  logic             flush_i,
  input  logic [SlotW-1:0] push_slot_i,
  input  logic             full_i,
  input  logic             head_valid_i,
  input  logic [SlotW-1:0] head_slot_i,
  output logic             push_o,
  output id_t              push_id_o,
  output id_t              lookup_id_o,
  output logic             pop_o,
  output fault_t           fault_o
);

  localparam int unsigned FillW = $clog2(MaxTxns + 1);

  typedef logic [SlotW-1:0] slot_t;
  typedef enum logic {PH_DATA, PH_RESP} phase_e;

  logic   busy_q  [MaxTxns];
  phase_e phase_q [MaxTxns];
  cnt_t   cnt_q   [MaxTxns];
  id_t    id_q    [MaxTxns];
  addr_t  addr_q  [MaxTxns];

  // Slots waiting for their W-last, in AW order
  slot_t            fifo_q [MaxTxns];
  slot_t            rd_ptr_q, wr_ptr_q;
  logic [FillW-1:0] fill_q;
  logic             fifo_empty;
  slot_t            wslot;

  logic  aw_hs, wlast_hs, b_hs, b_match, wlast_go;
  logic  unwanted_b, overflow, stray_w, wlast_late, late_found;
  slot_t late_slot;
  cnt_t  late_cnt;

  function automatic slot_t wrap_inc(slot_t ptr);
    return (ptr == slot_t'(MaxTxns - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign aw_hs      = aw_i.valid && aw_i.ready;
  assign wlast_hs   = w_i.valid && w_i.ready && w_i.last;
  assign b_hs       = b_i.valid && b_i.ready;
  assign fifo_empty = (fill_q == '0);
  assign wslot      = fifo_q[rd_ptr_q];

  // A B only completes the oldest write of its ID once that write waits for B
  assign b_match  = head_valid_i && (phase_q[head_slot_i] == PH_RESP);
  assign push_o   = aw_hs && !full_i && !frozen_i;
  assign pop_o    = b_hs && b_match && !frozen_i;
  assign wlast_go = wlast_hs && !fifo_empty && !frozen_i;

  assign push_id_o   = aw_i.id;
  assign lookup_id_o = b_i.id;

  assign unwanted_b = b_hs && !b_match;
  assign overflow   = aw_hs && full_i;
  assign stray_w    = wlast_hs && fifo_empty;
  // FIFO head is the oldest write in DATA and so has the largest count
  assign wlast_late = !fifo_empty && (cnt_q[wslot] >= budgets_i.aw_wlast);

  // Oldest late write in RESP, the one with the largest count
  always_comb begin
    late_found = 1'b0;
    late_slot  = '0;
    late_cnt   = '0;
    for (int i = 0; i < MaxTxns; i++) begin
      if (busy_q[i] && (phase_q[i] == PH_RESP) && (cnt_q[i] >= budgets_i.wlast_b) &&
          (!late_found || (cnt_q[i] > late_cnt))) begin
        late_found = 1'b1;
        late_slot  = slot_t'(i);
        late_cnt   = cnt_q[i];
      end
    end
  end

  always_comb begin
    fault_o = '0;
    if (!frozen_i) begin
      if (unwanted_b) begin
        fault_o = '{valid: 1'b1, cause: UNWANTED_B, id: b_i.id, addr: '0};
      end else if (overflow) begin
        fault_o = '{valid: 1'b1, cause: OVERFLOW, id: aw_i.id, addr: aw_i.addr};
      end else if (late_found) begin
        fault_o = '{valid: 1'b1, cause: B_LATE, id: id_q[late_slot], addr: addr_q[late_slot]};
      end else if (wlast_late) begin
        fault_o = '{valid: 1'b1, cause: WLAST_LATE, id: id_q[wslot], addr: addr_q[wslot]};
      end else if (stray_w) begin
        fault_o = '{valid: 1'b1, cause: STRAY_W, id: '0, addr: '0};
      end
    end
  end

  // Per-slot phase and cycle count since phase entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MaxTxns; i++) begin
        busy_q[i]  <= 1'b0;
        phase_q[i] <= PH_DATA;
        cnt_q[i]   <= '0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < MaxTxns; i++) begin
        busy_q[i] <= 1'b0;
      end
    end else if (!frozen_i) begin
      for (int i = 0; i < MaxTxns; i++) begin
        if (push_o && (push_slot_i == slot_t'(i))) begin
          busy_q[i]  <= 1'b1;
          phase_q[i] <= PH_DATA;
          cnt_q[i]   <= '0;
        end else if (wlast_go && (wslot == slot_t'(i))) begin
          phase_q[i] <= PH_RESP;
          cnt_q[i]   <= '0;
        end else if (pop_o && (head_slot_i == slot_t'(i))) begin
          busy_q[i] <= 1'b0;
        end else if (busy_q[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_o) begin
      id_q[push_slot_i]     <= aw_i.id;
      addr_q[push_slot_i]   <= aw_i.addr;
      fifo_q[wr_ptr_q]      <= push_slot_i;
    end
  end

  // W-order FIFO pointers, it cannot overflow since it never holds more than the pool
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      fill_q   <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_o) begin
        wr_ptr_q <= wrap_inc(wr_ptr_q);
      end
      if (wlast_go) begin
        rd_ptr_q <= wrap_inc(rd_ptr_q);
      end
      if (push_o && !wlast_go) begin
        fill_q <= fill_q + 1'b1;
      end else if (!push_o && wlast_go) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

endmodule

/* logic/write_guard.sv */
`timescale 1ns/1ns

module write_guard import guard_pkg::*; #(
  parameter int unsigned MaxTxns = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  aw_snap_t aw_i,
  input  w_snap_t  w_i,
  input  b_snap_t  b_i,
  input  cfg_wr_t  cfg_wr_i,
  input  logic     fault_clear_i,
  output logic     irq_o,
  output logic     reset_req_o,
  output fault_t   fault_o
);

  localparam int unsigned SlotW = $clog2(MaxTxns);

  budgets_t         budgets;
  logic             frozen, flush;
  fault_t           stall_fault, txn_fault;
  logic             push, pop, full, head_valid;
  id_t              push_id, lookup_id;
  logic [SlotW-1:0] push_slot, head_slot;

  guard_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_wr_i     (cfg_wr_i),
    .fault_clear_i(fault_clear_i),
    .stall_fault_i(stall_fault),
    .txn_fault_i  (txn_fault),
    .budgets_o    (budgets),
    .frozen_o     (frozen),
    .flush_o      (flush),
    .irq_o        (irq_o),
    .reset_req_o  (reset_req_o),
    .fault_o      (fault_o)
  );

  aw_stall_monitor u_stall (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .aw_i    (aw_i),
    .budget_i(budgets.aw_stall),
    .frozen_i(frozen),
    .flush_i (flush),
    .fault_o (stall_fault)
  );

  txn_tracker #(
    .MaxTxns(MaxTxns)
  ) u_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_i        (aw_i),
    .w_i         (w_i),
    .b_i         (b_i),
    .budgets_i   (budgets),
    .frozen_i    (frozen),
    .flush_i     (flush),
    .push_slot_i (push_slot),
    .full_i      (full),
    .head_valid_i(head_valid),
    .head_slot_i (head_slot),
    .push_o      (push),
    .push_id_o   (push_id),
    .lookup_id_o (lookup_id),
    .pop_o       (pop),
    .fault_o     (txn_fault)
  );

  id_queue #(
    .MaxTxns(MaxTxns)
  ) u_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .push_i      (push),
    .push_id_i   (push_id),
    .lookup_id_i (lookup_id),
    .pop_i       (pop),
    .push_slot_o (push_slot),
    .full_o      (full),
    .head_valid_o(head_valid),
    .head_slot_o (head_slot)
  );

endmodule

/* tb/tb_write_guard.sv */
`timescale 1ns/1ns

module tb_write_guard import guard_pkg::*; ();

  localparam int unsigned MaxTxns = 4;
  localparam int RandCycles = 3000;
  localparam int FreshCycles = 300;
  // Directed tests and drains stay well under the margin
  localparam int TimeoutCycles = RandCycles + FreshCycles + 1000;
  localparam w_snap_t WLast = '{valid: 1'b1, ready: 1'b1, last: 1'b1};

  // One outstanding write in the reference model
  typedef struct packed {
    id_t   id;
    addr_t addr;
    logic  resp;
    cnt_t  age;
  } rec_t;

  logic     clk_i;
  logic     rst_ni;
  aw_snap_t aw_i;
  w_snap_t  w_i;
  b_snap_t  b_i;
  cfg_wr_t  cfg_wr_i;
  logic     fault_clear_i;
  logic     irq_o;
  logic     reset_req_o;
  fault_t   fault_o;

  aw_snap_t    nx_aw;
  aw_snap_t    aw_hold;
  w_snap_t     nx_w;
  b_snap_t     nx_b;
  cfg_wr_t     nx_cfg;
  logic        nx_clr;
  int          traffic;
  logic [31:0] rng;
  int          cycles;

  rec_t     m_q[$];
  fault_t   m_fault;
  budgets_t m_bud;
  logic     m_flush;
  int       m_run;
  int       m_done;

  write_guard #(
    .MaxTxns(MaxTxns)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .aw_i         (aw_i),
    .w_i          (w_i),
    .b_i          (b_i),
    .cfg_wr_i     (cfg_wr_i),
    .fault_clear_i(fault_clear_i),
    .irq_o        (irq_o),
    .reset_req_o  (reset_req_o),
    .fault_o      (fault_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      stop_run($sformatf("timeout: the run went past %0d cycles", TimeoutCycles));
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic aw_snap_t aw_beat(input id_t id, input addr_t addr);
    return '{valid: 1'b1, ready: 1'b1, id: id, addr: addr};
  endfunction

  function automatic b_snap_t b_beat(input id_t id);
    return '{valid: 1'b1, ready: 1'b1, id: id};
  endfunction

  // True when no older outstanding write shares this entry's ID
  function automatic logic first_of_id(input int i);
    for (int j = 0; j < i; j++) begin
      if (m_q[j].id == m_q[i].id) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  // Applies the watchdog rules to the inputs sampled at this edge
  task automatic model_step();
    fault_t ev;
    rec_t   rec;
    logic   frozen, aw_hs, wl_hs, b_hs, stalled, b_ok;
    int     di, bi, li, n_pre;
    frozen  = m_fault.valid | fault_clear_i | m_flush;
    aw_hs   = aw_i.valid & aw_i.ready;
    wl_hs   = w_i.valid & w_i.ready & w_i.last;
    b_hs    = b_i.valid & b_i.ready;
    stalled = aw_i.valid & ~aw_i.ready;
    n_pre   = m_q.size();
    di = -1;
    bi = -1;
    li = -1;
    foreach (m_q[i]) begin
      if (!m_q[i].resp && di < 0) di = i;
      if (m_q[i].id == b_i.id && bi < 0) bi = i;
      if (m_q[i].resp && m_q[i].age >= m_bud.wlast_b && li < 0) li = i;
    end
    b_ok = (bi >= 0) && m_q[bi].resp;
    ev = '0;
    if (!frozen) begin
      if (b_hs && !b_ok) begin
        ev = '{valid: 1'b1, cause: UNWANTED_B, id: b_i.id, addr: '0};
      end else if (aw_hs && n_pre == MaxTxns) begin
        ev = '{valid: 1'b1, cause: OVERFLOW, id: aw_i.id, addr: aw_i.addr};
      end else if (li >= 0) begin
        ev = '{valid: 1'b1, cause: B_LATE, id: m_q[li].id, addr: m_q[li].addr};
      end else if (di >= 0 && m_q[di].age >= m_bud.aw_wlast) begin
        ev = '{valid: 1'b1, cause: WLAST_LATE, id: m_q[di].id, addr: m_q[di].addr};
      end else if (wl_hs && di < 0) begin
        ev = '{valid: 1'b1, cause: STRAY_W, id: '0, addr: '0};
      end else if (stalled && m_run >= m_bud.aw_stall) begin
        ev = '{valid: 1'b1, cause: AW_STALL, id: aw_i.id, addr: aw_i.addr};
      end
    end
    if (m_flush) begin
      m_q.delete();
      m_run = 0;
    end else if (!frozen) begin
      foreach (m_q[i]) begin
        if (m_q[i].age != 8'hff) m_q[i].age = m_q[i].age + 1'b1;
      end
      if (wl_hs && di >= 0) begin
        m_q[di].resp = 1'b1;
        m_q[di].age  = '0;
      end
      if (b_hs && b_ok) begin
        m_q.delete(bi);
        m_done++;
      end
      if (aw_hs && n_pre < MaxTxns) begin
        rec = '{id: aw_i.id, addr: aw_i.addr, resp: 1'b0, age: '0};
        m_q.push_back(rec);
      end
      m_run = stalled ? ((m_run < 255) ? m_run + 1 : m_run) : 0;
    end
    if (fault_clear_i) begin
      m_fault = '0;
    end else if (ev.valid) begin
      m_fault = ev;
    end
    m_flush = fault_clear_i;
    if (cfg_wr_i.we) begin
      case (cfg_wr_i.addr)
        RegAwStall: m_bud.aw_stall = cfg_wr_i.data;
        RegAwWlast: m_bud.aw_wlast = cfg_wr_i.data;
        RegWlastB:  m_bud.wlast_b  = cfg_wr_i.data;
        default: begin
        end
      endcase
    end
  endtask

  // Legal traffic for the next edge that forces W-last, B and AW ready before a budget runs out
  task automatic plan_traffic(input logic allow_aw);
    logic [31:0] r;
    int          di, bo, bn;
    rng = xorshift32(rng);
    r = rng;
    di = -1;
    bo = -1;
    bn = -1;
    foreach (m_q[i]) begin
      if (!m_q[i].resp && di < 0) di = i;
      if (m_q[i].resp && first_of_id(i)) begin
        bn = i;
        if (bo < 0 || m_q[i].age > m_q[bo].age) bo = i;
      end
    end
    rng = xorshift32(rng);
    nx_aw.valid = allow_aw && r[0] && (m_q.size() < MaxTxns);
    nx_aw.ready = r[1] || (m_run + 1 >= m_bud.aw_stall);
    nx_aw.id    = id_t'(r[5:4]);
    nx_aw.addr  = rng;
    nx_w = '{valid: r[2], ready: r[3], last: r[6] && (di >= 0)};
    if (di >= 0 && m_q[di].age + 3 >= m_bud.aw_wlast) nx_w = WLast;
    nx_b = '{valid: r[7], ready: 1'b0, id: id_t'(r[11:8])};
    if (bo >= 0 && m_q[bo].age + 3 >= m_bud.wlast_b) begin
      nx_b = b_beat(m_q[bo].id);
    end else if (bo >= 0 && r[12]) begin
      nx_b = b_beat(r[13] ? m_q[bn].id : m_q[bo].id);
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    model_step();
    if (traffic != 0) plan_traffic(traffic == 1);
    aw_i          <= nx_aw;
    w_i           <= nx_w;
    b_i           <= nx_b;
    cfg_wr_i      <= nx_cfg;
    fault_clear_i <= nx_clr;
    nx_aw  = aw_hold;
    nx_w   = '0;
    nx_b   = '0;
    nx_cfg = '0;
    nx_clr = 1'b0;
    @(negedge clk_i);
    check("irq_o", irq_o, m_fault.valid);
    check("reset_req_o", reset_req_o, m_fault.valid);
    check("fault_o", fault_o, m_fault);
  endtask

  task automatic cfg_write(input logic [1:0] addr, input cnt_t data);
    nx_cfg = '{we: 1'b1, addr: addr, data: data};
    tick();
  endtask

  task automatic wait_fault(input int max_cycles, output int n);
    n = 0;
    while (!irq_o && n < max_cycles) begin
      tick();
      n++;
    end
    if (!irq_o) stop_run($sformatf("no fault was raised within %0d cycles", max_cycles));
  endtask

  task automatic expect_fault(input fault_cause_e cause, input id_t id, input addr_t addr);
    check("fault_o.cause", fault_o.cause, cause);
    check("fault_o.id", fault_o.id, id);
    check("fault_o.addr", fault_o.addr, addr);
  endtask

  // Clear edge, flush edge, then one idle edge
  task automatic clear_fault();
    nx_clr = 1'b1;
    repeat (3) tick();
    check("irq_o after clear", irq_o, 1'b0);
  endtask

  task automatic drain();
    int n;
    traffic = 2;
    tick();
    n = 1;
    while (m_q.size() != 0 && n < 200) begin
      tick();
      n++;
    end
    if (m_q.size() != 0) stop_run("outstanding writes did not drain within 200 cycles");
    traffic = 0;
  endtask

  task automatic stall_run(input id_t id, input addr_t addr, input int exp_edges);
    int n;
    aw_hold = '{valid: 1'b1, ready: 1'b0, id: id, addr: addr};
    nx_aw = aw_hold;
    tick();
    wait_fault(40, n);
    aw_hold = '0;
    nx_aw = '0;
    check("stall edges", n, exp_edges);
    expect_fault(AW_STALL, id, addr);
    clear_fault();
  endtask

  initial begin
    int     n;
    fault_t held;
    rst_ni = 1'b0;
    aw_i = '0;
    w_i = '0;
    b_i = '0;
    cfg_wr_i = '0;
    fault_clear_i = 1'b0;
    nx_aw = '0;
    aw_hold = '0;
    nx_w = '0;
    nx_b = '0;
    nx_cfg = '0;
    nx_clr = 1'b0;
    traffic = 0;
    rng = 32'd2;
    cycles = 0;
    m_fault = '0;
    m_bud = '{aw_stall: DefAwStall, aw_wlast: DefAwWlast, wlast_b: DefWlastB};
    m_flush = 1'b0;
    m_run = 0;
    m_done = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Legal random traffic over four IDs must stay fault free
    traffic = 1;
    repeat (RandCycles) tick();
    drain();
    check("irq_o after traffic", irq_o, 1'b0);
    if (m_done < 100) stop_run("random traffic completed fewer than 100 writes");

    // Default stall budget, then a reprogrammed one
    stall_run(4'd6, 32'h1000_0100, DefAwStall + 1);
    cfg_write(RegAwStall, 8'd3);
    cfg_write(2'd3, 8'd1);
    stall_run(4'd7, 32'h1000_0200, 4);

    // Late W-last reports the oldest write
    cfg_write(RegAwWlast, 8'd5);
    nx_aw = aw_beat(4'd5, 32'h2000_0010);
    tick();
    nx_aw = aw_beat(4'd6, 32'h2000_0020);
    tick();
    wait_fault(30, n);
    check("wlast late edges", n, 6);
    expect_fault(WLAST_LATE, 4'd5, 32'h2000_0010);
    clear_fault();
    cfg_write(RegAwWlast, DefAwWlast);

    cfg_write(RegWlastB, 8'd4);
    nx_aw = aw_beat(4'd2, 32'h3000_0040);
    tick();
    nx_w = WLast;
    tick();
    wait_fault(30, n);
    check("b late edges", n, 6);
    expect_fault(B_LATE, 4'd2, 32'h3000_0040);
    clear_fault();
    cfg_write(RegWlastB, DefWlastB);

    // Protocol faults
    nx_b = b_beat(4'd9);
    tick();
    wait_fault(4, n);
    expect_fault(UNWANTED_B, 4'd9, '0);
    clear_fault();
    nx_aw = aw_beat(4'd3, 32'h4000_0000);
    tick();
    nx_b = b_beat(4'd3);
    tick();
    wait_fault(4, n);
    expect_fault(UNWANTED_B, 4'd3, '0);
    clear_fault();
    nx_w = WLast;
    tick();
    wait_fault(4, n);
    expect_fault(STRAY_W, '0, '0);
    clear_fault();
    for (int i = 0; i < 4; i++) begin
      nx_aw = aw_beat(id_t'(i), 32'h5000_0000 + i);
      tick();
    end
    nx_aw = aw_beat(4'd4, 32'h5000_0ff0);
    tick();
    wait_fault(4, n);
    expect_fault(OVERFLOW, 4'd4, 32'h5000_0ff0);

    // Record holds while frozen whatever the link does
    held = fault_o;
    for (int i = 0; i < 10; i++) begin
      nx_aw = aw_beat(id_t'(i), 32'h6000_0000);
      nx_w = WLast;
      nx_b = b_beat(id_t'(i));
      tick();
      check("frozen fault_o", fault_o, held);
    end
    clear_fault();
    // Four writes still waited for data before the clear and the flush drops them
    nx_w = WLast;
    tick();
    wait_fault(4, n);
    expect_fault(STRAY_W, '0, '0);
    clear_fault();

    // Priority among faults at one edge
    nx_b = b_beat(4'd7);
    nx_w = WLast;
    tick();
    wait_fault(4, n);
    expect_fault(UNWANTED_B, 4'd7, '0);
    clear_fault();
    for (int i = 0; i < 4; i++) begin
      nx_aw = aw_beat(id_t'(i), 32'h7000_0000 + i);
      tick();
    end
    repeat (4) begin
      nx_w = WLast;
      tick();
    end
    nx_aw = aw_beat(4'd8, 32'h7000_0800);
    nx_w = WLast;
    tick();
    wait_fault(4, n);
    expect_fault(OVERFLOW, 4'd8, 32'h7000_0800);
    clear_fault();

    // Fresh traffic after the clear
    nx_aw = aw_beat(4'd1, 32'h8000_0000);
    tick();
    nx_w = WLast;
    tick();
    nx_b = b_beat(4'd1);
    tick();
    traffic = 1;
    repeat (FreshCycles) tick();
    drain();
    repeat (4) tick();
    check("irq_o after fresh traffic", irq_o, 1'b0);

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* src.f */
logic/guard_pkg.sv
logic/guard_regs.sv
logic/aw_stall_monitor.sv
logic/id_queue.sv
logic/txn_tracker.sv
logic/write_guard.sv
tb/tb_write_guard.sv

/* Bender.yml */
package:
  name: write_guard

sources:
  - logic/guard_pkg.sv
  - logic/guard_regs.sv
  - logic/aw_stall_monitor.sv
  - logic/id_queue.sv
  - logic/txn_tracker.sv
  - logic/write_guard.sv
  - target: test
    files:
      - tb/tb_write_guard.sv
